/* source/eeprom_cmd_pkg.sv */
package eeprom_cmd_pkg;

    // host opcode
    typedef enum logic {
        CMD_WRITE = 1'b0,
        CMD_READ  = 1'b1
    } cmd_op_e;

    // one host transaction held stable while req is high
    typedef struct packed {
        cmd_op_e     op;
        logic [10:0] addr;  // a10..a8 pick the 256-byte block
        logic [7:0]  wdata;
    } eeprom_cmd_t;

    // valid while ack is high
    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;   // device did not acknowledge
    } eeprom_rsp_t;

endpackage

/* source/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    // 24Cxx device type identifier in the upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // BUS_START doubles as repeated start
    typedef enum logic [1:0] {
        BUS_START = 2'd0,
        BUS_WRITE = 2'd1,
        BUS_READ  = 2'd2,
        BUS_STOP  = 2'd3
    } bus_op_e;

    typedef struct packed {
        bus_op_e    op;
        logic [7:0] wbyte;
        logic       last;   // master NACKs the read byte
    } bus_req_t;

    typedef struct packed {
        logic [7:0] rbyte;
        logic       acked;  // slave ACK after a write
    } bus_rsp_t;

endpackage

/* source/i2c_bit_engine.sv */
`timescale 1ns/1ps
module i2c_bit_engine #(
    parameter int SCL_DIV = 2
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  op_req,
    input  i2c_bus_pkg::bus_req_t op,
    output logic                  op_ack,
    output i2c_bus_pkg::bus_rsp_t op_rsp,
    output logic                  scl_low,
    output logic                  sda_low,
    input  logic                  sda_in
);

    typedef enum logic [2:0] {
        IDLE,
        START,
        SHIFT,
        STOP,
        DONE
    } bit_state_e;

    localparam int DIV_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

    bit_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       phase;    // 0 setup, 1 scl up, 2 sample, 3 scl down
    logic [3:0]       bit_cnt;  // 0..7 data, 8 ack slot
    logic [7:0]       shreg;
    logic             is_read;
    logic             last_q;
    logic             acked;
    logic             tick;
    logic             ack_slot;
    logic             drv_scl;
    logic             drv_sda;

    assign tick     = (div_cnt == DIV_W'(SCL_DIV - 1));
    assign ack_slot = (bit_cnt == 4'd8);
    assign op_rsp   = '{rbyte: shreg, acked: acked};

    // line drive wanted for the current phase
    always_comb begin
        drv_scl = (phase == 2'd0) || (phase == 2'd3);
        drv_sda = sda_low;
        case (state)
            START: drv_sda = phase[1];          // sda falls while scl high
            STOP: begin
                drv_scl = (phase == 2'd0);      // scl stays released at the end
                drv_sda = !phase[1];            // sda rises while scl high
            end
            SHIFT: begin
                if (ack_slot)
                    drv_sda = is_read && !last_q;
                else
                    drv_sda = !is_read && !shreg[7];
            end
            default: drv_scl = scl_low;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= IDLE;
            div_cnt <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
            op_ack  <= 1'b0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            if (state inside {START, SHIFT, STOP}) begin
                scl_low <= drv_scl;     // outputs trail the phase by one cycle
                sda_low <= drv_sda;
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (op_req) begin
                        div_cnt <= '0;
                        phase   <= 2'd0;
                        bit_cnt <= 4'd0;
                        shreg   <= op.wbyte;
                        is_read <= (op.op == i2c_bus_pkg::BUS_READ);
                        last_q  <= op.last;
                        case (op.op)
                            i2c_bus_pkg::BUS_START: state <= START;
                            i2c_bus_pkg::BUS_STOP:  state <= STOP;
                            default:                state <= SHIFT;
                        endcase
                    end
                end
                START, STOP: begin
                    if (tick) begin
                        phase <= phase + 2'd1;
                        if (phase == 2'd3) begin
                            state  <= DONE;
                            op_ack <= 1'b1;
                        end
                    end
                end
                SHIFT: begin
                    if (tick) begin
                        phase <= phase + 2'd1;
                        if (phase == 2'd2) begin    // mid-high once the lag is counted
                            if (ack_slot)
                                acked <= !sda_in;
                            else if (is_read)
                                shreg <= {shreg[6:0], sda_in};
                        end
                        if (phase == 2'd3) begin
                            if (ack_slot) begin
                                state  <= DONE;
                                op_ack <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                                if (!is_read)
                                    shreg <= {shreg[6:0], 1'b0};
                            end
                        end
                    end
                end
                DONE: begin
                    if (!op_req) begin
                        op_ack <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/eeprom_sequencer.sv */
`timescale 1ns/1ps
module eeprom_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req,
    input  eeprom_cmd_pkg::eeprom_cmd_t cmd,
    output logic                      ack,
    output eeprom_cmd_pkg::eeprom_rsp_t rsp,
    output logic                      op_req,
    output i2c_bus_pkg::bus_req_t     op,
    input  logic                      op_ack,
    input  i2c_bus_pkg::bus_rsp_t     op_rsp
);

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } seq_state_e;

    typedef enum logic {
        ISSUE,
        WAIT
    } hs_phase_e;

    seq_state_e                  state;
    seq_state_e                  after_state;
    hs_phase_e                   hs;
    eeprom_cmd_pkg::eeprom_cmd_t cmd_q;
    logic [7:0]                  rdata_q;
    logic                        nack_q;
    i2c_bus_pkg::bus_req_t       next_op;

    assign rsp = '{rdata: rdata_q, nack: nack_q};

    // bus operation for the current step
    always_comb begin
        next_op = '{op: i2c_bus_pkg::BUS_WRITE, wbyte: 8'h00, last: 1'b0};
        case (state)
            START, RESTART: next_op.op = i2c_bus_pkg::BUS_START;
            CTRL_W: next_op.wbyte = {i2c_bus_pkg::DEVICE_CODE, cmd_q.addr[10:8], 1'b0};
            ADDR:   next_op.wbyte = cmd_q.addr[7:0];
            DATA_W: next_op.wbyte = cmd_q.wdata;
            CTRL_R: next_op.wbyte = {i2c_bus_pkg::DEVICE_CODE, cmd_q.addr[10:8], 1'b1};
            DATA_R: begin
                next_op.op   = i2c_bus_pkg::BUS_READ;
                next_op.last = 1'b1;    // single byte gets a NACK
            end
            STOP: next_op.op = i2c_bus_pkg::BUS_STOP;
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            START:   after_state = CTRL_W;
            CTRL_W:  after_state = ADDR;
            ADDR:    after_state = (cmd_q.op == eeprom_cmd_pkg::CMD_READ) ? RESTART : DATA_W;
            RESTART: after_state = CTRL_R;
            CTRL_R:  after_state = DATA_R;
            STOP:    after_state = DONE;
            default: after_state = STOP;    // DATA_W, DATA_R
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= IDLE;
            hs     <= ISSUE;
            ack    <= 1'b0;
            op_req <= 1'b0;
            nack_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        cmd_q   <= cmd;
                        nack_q  <= 1'b0;
                        rdata_q <= 8'h00;
                        hs      <= ISSUE;
                        state   <= START;
                    end
                end
                DONE: begin
                    if (!req) begin     // host saw the response
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    if (hs == ISSUE && !op_ack) begin
                        op     <= next_op;
                        op_req <= 1'b1;
                        hs     <= WAIT;
                    end else if (hs == WAIT && op_ack) begin
                        op_req <= 1'b0;
                        hs     <= ISSUE;
                        if (state == DATA_R)
                            rdata_q <= op_rsp.rbyte;
                        if (op.op == i2c_bus_pkg::BUS_WRITE && !op_rsp.acked) begin
                            nack_q <= 1'b1;
                            state  <= STOP;     // abort the rest
                        end else begin
                            state <= after_state;
                        end
                        if (state == STOP)
                            ack <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* source/eeprom_ctrl.sv */
`timescale 1ns/1ps
module eeprom_ctrl #(
    parameter int SCL_DIV = 2   // CLK cycles per quarter SCL period
) (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        req,
    input  eeprom_cmd_pkg::eeprom_cmd_t cmd,
    output logic                        ack,
    output eeprom_cmd_pkg::eeprom_rsp_t rsp,
    output logic                        scl_low,
    output logic                        sda_low,
    input  logic                        scl_in,     // line monitor only
    input  logic                        sda_in
);

    logic                  op_req;
    logic                  op_ack;
    i2c_bus_pkg::bus_req_t op;
    i2c_bus_pkg::bus_rsp_t op_rsp;

    eeprom_sequencer u_seq (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .rsp    (rsp),
        .op_req (op_req),
        .op     (op),
        .op_ack (op_ack),
        .op_rsp (op_rsp)
    );

    i2c_bit_engine #(
        .SCL_DIV (SCL_DIV)
    ) u_bit (
        .CLK     (CLK),
        .RESET   (RESET),
        .op_req  (op_req),
        .op      (op),
        .op_ack  (op_ack),
        .op_rsp  (op_rsp),
        .scl_low (scl_low),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
module tb_clk_gen #(
    parameter int HALF_NS = 50  // 100 ns period
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(HALF_NS) CLK = ~CLK;
    end

endmodule

/* dv/eeprom_model.sv */
`timescale 1ns/1ps
module eeprom_model (
    input  logic enable,
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    logic [7:0] mem [0:2047];
    logic [7:0] shreg;
    logic [7:0] word;
    logic [7:0] rbuf;
    logic [2:0] block;
    logic [3:0] bit_cnt;    // 8 after data bits, 9 after ack slot
    logic [1:0] byte_no;
    logic       scl_q;
    logic       sda_q;
    logic       in_frame;
    logic       sending;
    logic       send_next;
    logic       master_ack;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3);
        sda_low   = 1'b0;
        in_frame  = 1'b0;
        sending   = 1'b0;
        send_next = 1'b0;
        bit_cnt   = 4'd0;
        byte_no   = 2'd0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
    end

    always @(scl or sda) begin
        if (scl_q && scl && (sda_q != sda)) begin
            in_frame  = !sda;   // falling sda is a start, rising a stop
            sending   = 1'b0;
            send_next = 1'b0;
            bit_cnt   = 4'd0;
            byte_no   = 2'd0;
            sda_low   = 1'b0;
        end else if (in_frame && !scl_q && scl) begin
            if (bit_cnt < 4'd8) begin
                if (!sending)
                    shreg = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 4'd1;
            end else begin
                master_ack = !sda;
                bit_cnt    = 4'd9;
            end
        end else if (in_frame && scl_q && !scl) begin
            if (bit_cnt == 4'd8) begin
                if (sending) begin
                    sda_low = 1'b0;     // master answers
                end else begin
                    case (byte_no)
                        2'd0: begin
                            if (enable && shreg[7:4] == i2c_bus_pkg::DEVICE_CODE) begin
                                block     = shreg[3:1];
                                send_next = shreg[0];
                                sda_low   = 1'b1;
                            end else begin
                                in_frame = 1'b0;    // not addressed
                            end
                        end
                        2'd1: begin
                            word    = shreg;
                            sda_low = 1'b1;
                        end
                        default: begin
                            mem[{block, word}] = shreg;
                            word    = word + 8'd1;
                            sda_low = 1'b1;
                        end
                    endcase
                    if (byte_no != 2'd2)
                        byte_no = byte_no + 2'd1;
                end
            end else if (bit_cnt == 4'd9) begin
                bit_cnt = 4'd0;
                sda_low = 1'b0;
                if (sending && !master_ack) begin
                    sending  = 1'b0;
                    in_frame = 1'b0;
                end else if (sending || send_next) begin
                    if (sending)
                        word = word + 8'd1;
                    sending   = 1'b1;
                    send_next = 1'b0;
                    rbuf      = mem[{block, word}];
                    sda_low   = !rbuf[7];
                end
            end else if (sending && bit_cnt != 4'd0) begin
                sda_low = !rbuf[3'd7 - bit_cnt[2:0]];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* dv/eeprom_ctrl_asserts.sv */
`timescale 1ns/1ps
module eeprom_ctrl_asserts (
    input logic                        CLK,
    input logic                        RESET,
    input logic                        req,
    input logic                        ack,
    input eeprom_cmd_pkg::eeprom_rsp_t rsp,
    input logic                        scl_low,
    input logic                        sda_low,
    input logic [3:0]                  seq_state
);

    ack_needs_req: assert property (@(posedge CLK) disable iff (RESET) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    rsp_stable: assert property (@(posedge CLK) disable iff (RESET)
        ack && $past(ack) |-> $stable(rsp))
        else $error("rsp changed while ack was high");

    // sequencer IDLE is encoding 0
    bus_idle: assert property (@(posedge CLK) disable iff (RESET)
        (seq_state == 4'd0) && !ack |-> !scl_low && !sda_low)
        else $error("bus driven while controller idle");

endmodule

bind eeprom_ctrl eeprom_ctrl_asserts u_asserts (
    .CLK       (CLK),
    .RESET     (RESET),
    .req       (req),
    .ack       (ack),
    .rsp       (rsp),
    .scl_low   (scl_low),
    .sda_low   (sda_low),
    .seq_state (u_seq.state)
);

/* dv/tb_eeprom_ctrl.sv */
`timescale 1ns/1ps
module tb_eeprom_ctrl;

    localparam int SCL_DIV = 2;
    localparam int TIMEOUT = 3000;  // wait limit in cycles, well above one read

    logic                        CLK;
    logic                        RESET;
    logic                        req;
    logic                        ack;
    logic                        scl_low;
    logic                        sda_low;
    logic                        model_sda_low;
    logic                        model_en;
    logic                        hung;
    wire                         scl;
    wire                         sda;
    eeprom_cmd_pkg::eeprom_cmd_t cmd;
    eeprom_cmd_pkg::eeprom_rsp_t rsp;
    logic [7:0]                  ref_mem [0:2047];
    int                          errors;
    int                          xfers;
    int                          seed;

    // wired-AND with pull-ups
    assign scl = !scl_low;
    assign sda = !(sda_low || model_sda_low);

    tb_clk_gen u_clk (.CLK(CLK));

    eeprom_ctrl #(
        .SCL_DIV (SCL_DIV)
    ) u_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .cmd     (cmd),
        .ack     (ack),
        .rsp     (rsp),
        .scl_low (scl_low),
        .sda_low (sda_low),
        .scl_in  (scl),
        .sda_in  (sda)
    );

    eeprom_model u_mem (
        .enable  (model_en),
        .scl     (scl),
        .sda     (sda),
        .sda_low (model_sda_low)
    );

    always @(posedge CLK) begin
        if (hung) begin
            $display("%0d transactions, %0d errors, stopped on a timeout", xfers, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input string what, input int exp,
                                   input int act);
        errors++;
        $display("Fail %s %s: expected %0h actual %0h", test, what, exp, act);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < TIMEOUT) begin
            @(posedge CLK);
            n++;
        end
        if (ack !== level) begin
            $display("ack never went to %0b within %0d cycles", level, TIMEOUT);
            hung = 1'b1;
            forever @(posedge CLK);
        end
    endtask

    // four-phase host handshake
    task automatic host_xfer(input eeprom_cmd_pkg::cmd_op_e op, input logic [10:0] addr,
                             input logic [7:0] wdata, output eeprom_cmd_pkg::eeprom_rsp_t r);
        @(posedge CLK);
        req <= 1'b1;
        cmd <= '{op: op, addr: addr, wdata: wdata};
        wait_ack(1'b1);
        r = rsp;
        req <= 1'b0;
        wait_ack(1'b0);
        xfers++;
    endtask

    task automatic write_byte(input string test, input logic [10:0] addr,
                              input logic [7:0] data);
        eeprom_cmd_pkg::eeprom_rsp_t r;
        host_xfer(eeprom_cmd_pkg::CMD_WRITE, addr, data, r);
        if (r.nack !== 1'b0)
            report_mismatch(test, "write nack", 0, int'(r.nack));
        ref_mem[addr] = data;
    endtask

    task automatic read_check(input string test, input logic [10:0] addr);
        eeprom_cmd_pkg::eeprom_rsp_t r;
        host_xfer(eeprom_cmd_pkg::CMD_READ, addr, 8'h00, r);
        if (r.nack !== 1'b0)
            report_mismatch(test, "read nack", 0, int'(r.nack));
        if (r.rdata !== ref_mem[addr])
            report_mismatch(test, $sformatf("rdata @%03h", addr), int'(ref_mem[addr]),
                            int'(r.rdata));
    endtask

    task automatic check_reset_state();
        if (ack !== 1'b0)
            report_mismatch("reset", "ack", 0, int'(ack));
        if ({scl, sda} !== 2'b11)
            report_mismatch("reset", "scl/sda", 3, int'({scl, sda}));
    endtask

    task automatic single_write_read();
        write_byte("write_read", 11'h000, 8'h5A);
        read_check("write_read", 11'h000);
    endtask

    task automatic random_block_access();
        logic [10:0] addrs [16];
        logic [7:0]  lo [2];
        lo[0] = 8'($random(seed));
        lo[1] = 8'($random(seed));
        for (int i = 0; i < 16; i++) begin
            addrs[i] = {3'(i), lo[i / 8]};    // same word offset in every block
            write_byte("random_blocks", addrs[i], 8'($random(seed)));
        end
        for (int i = 0; i < 16; i++)
            read_check("random_blocks", addrs[(i * 7) % 16]);
    endtask

    task automatic overwrite_same_addr();
        write_byte("overwrite", 11'h2F1, 8'h11);
        write_byte("overwrite", 11'h2F0, 8'h22);
        write_byte("overwrite", 11'h2F0, 8'h33);
        read_check("overwrite", 11'h2F0);
        read_check("overwrite", 11'h2F1);
    endtask

    task automatic absent_device();
        eeprom_cmd_pkg::eeprom_rsp_t r;
        @(posedge CLK);
        model_en <= 1'b0;
        host_xfer(eeprom_cmd_pkg::CMD_WRITE, 11'h155, 8'hC3, r);
        if (r.nack !== 1'b1)
            report_mismatch("device_absent", "write nack", 1, int'(r.nack));
        if ({scl, sda} !== 2'b11)
            report_mismatch("device_absent", "scl/sda", 3, int'({scl, sda}));
        host_xfer(eeprom_cmd_pkg::CMD_READ, 11'h155, 8'h00, r);
        if (r.nack !== 1'b1)
            report_mismatch("device_absent", "read nack", 1, int'(r.nack));
        if ({scl, sda} !== 2'b11)
            report_mismatch("device_absent", "scl/sda", 3, int'({scl, sda}));
        @(posedge CLK);
        model_en <= 1'b1;
        write_byte("device_absent", 11'h155, 8'h3C);
        read_check("device_absent", 11'h155);
    endtask

    task automatic req_backpressure();
        eeprom_cmd_pkg::eeprom_rsp_t r;
        write_byte("backpressure", 11'h7A4, 8'h96);
        @(posedge CLK);
        req <= 1'b1;
        cmd <= '{op: eeprom_cmd_pkg::CMD_READ, addr: 11'h7A4, wdata: 8'h00};
        wait_ack(1'b1);
        r = rsp;
        if (r.nack !== 1'b0)
            report_mismatch("backpressure", "read nack", 0, int'(r.nack));
        if (r.rdata !== ref_mem[11'h7A4])
            report_mismatch("backpressure", "rdata", int'(ref_mem[11'h7A4]), int'(r.rdata));
        repeat (50) begin
            @(posedge CLK);
            if (ack !== 1'b1)
                report_mismatch("backpressure", "ack", 1, int'(ack));
            if (rsp !== r)
                report_mismatch("backpressure", "rsp", int'(r), int'(rsp));
            if ({scl, sda} !== 2'b11)
                report_mismatch("backpressure", "scl/sda", 3, int'({scl, sda}));
        end
        req <= 1'b0;
        wait_ack(1'b0);
        xfers++;
    endtask

    initial begin
        RESET    = 1'b1;
        req      = 1'b0;
        cmd      = '0;
        model_en = 1'b1;
        hung     = 1'b0;
        errors   = 0;
        xfers    = 0;
        seed     = 76333;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        @(posedge CLK);
        check_reset_state();
        single_write_read();
        random_block_access();
        overwrite_same_addr();
        absent_device();
        req_backpressure();
        $display("%0d transactions, %0d errors", xfers, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* eeprom_ctrl.f */
source/eeprom_cmd_pkg.sv
source/i2c_bus_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl.sv
dv/tb_clk_gen.sv
dv/eeprom_model.sv
dv/eeprom_ctrl_asserts.sv
dv/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --Mdir obj_dir \
    --top-module tb_eeprom_ctrl -f eeprom_ctrl.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1
